// File: rtl/cmdPkg.sv
`default_nettype none

package cmdPkg;

   // Widths and depths
   localparam int DATA_WIDTH     = 8;
   localparam int ADDR_WIDTH     = 4;
   localparam int FIFO_DEPTH     = 8;
   localparam int REG_COUNT      = 1 << ADDR_WIDTH;
   localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

   typedef logic [DATA_WIDTH-1:0] byteT;
   typedef logic [ADDR_WIDTH-1:0] addrT;
   typedef logic [3:0]            aluFunT;

   // Command bytes seen on the receive side
   localparam byteT CMD_RF_WR     = 8'hAA;
   localparam byteT CMD_RF_RD     = 8'hBB;
   localparam byteT CMD_ALU_OPER  = 8'hCC;
   localparam byteT CMD_ALU_NOPER = 8'hDD;

   // ALU function codes 14 and 15 are left unused and give zero
   localparam aluFunT FUN_ADD  = 4'd0;
   localparam aluFunT FUN_SUB  = 4'd1;
   localparam aluFunT FUN_MUL  = 4'd2;
   localparam aluFunT FUN_DIV  = 4'd3;
   localparam aluFunT FUN_AND  = 4'd4;
   localparam aluFunT FUN_OR   = 4'd5;
   localparam aluFunT FUN_NAND = 4'd6;
   localparam aluFunT FUN_NOR  = 4'd7;
   localparam aluFunT FUN_XOR  = 4'd8;
   localparam aluFunT FUN_XNOR = 4'd9;
   localparam aluFunT FUN_EQ   = 4'd10;
   localparam aluFunT FUN_GT   = 4'd11;
   localparam aluFunT FUN_SHR  = 4'd12;
   localparam aluFunT FUN_SHL  = 4'd13;

   typedef struct packed {
      logic wrEn;
      logic rdEn;
      addrT addr;
      byteT wrData;
   } rfReqT;

   typedef struct packed {
      logic   en;
      aluFunT fun;
   } aluReqT;

endpackage

`default_nettype wire

// File: rtl/txFifo.sv
`timescale 1ns/10ps
`default_nettype none

module txFifo
   import cmdPkg::*;
(
   input  wire       CLK,
   input  wire       RST,
   input  wire       push,
   input  wire byteT pushData,
   input  wire       pop,
   output byteT      popData,
   output logic      full,
   output logic      empty
);

   byteT                      mem [FIFO_DEPTH];
   logic [FIFO_PTR_WIDTH:0]   wrPtr;
   logic [FIFO_PTR_WIDTH:0]   rdPtr;
   logic                      doPush;
   logic                      doPop;

   assign doPush = push && !full;
   assign doPop  = pop && !empty;

   // Extra pointer bit tells full from empty
   assign empty = (wrPtr == rdPtr);
   assign full  = (wrPtr[FIFO_PTR_WIDTH] != rdPtr[FIFO_PTR_WIDTH]) &&
                  (wrPtr[FIFO_PTR_WIDTH-1:0] == rdPtr[FIFO_PTR_WIDTH-1:0]);

   assign popData = mem[rdPtr[FIFO_PTR_WIDTH-1:0]];

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= wrPtr + 1;
         if (doPop)
            rdPtr <= rdPtr + 1;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (doPush)
         mem[wrPtr[FIFO_PTR_WIDTH-1:0]] <= pushData;
   end

   // Producer and consumer both honor the flags
   assert property (@(posedge CLK) disable iff (!RST) push |-> !full);
   assert property (@(posedge CLK) disable iff (!RST) pop |-> !empty);

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile
   import cmdPkg::*;
(
   input  wire        CLK,
   input  wire        RST,
   input  wire rfReqT rfReq,
   output byteT       rdData,
   output logic       rdValid,
   output byteT       operandA,
   output byteT       operandB
);

   byteT regs [REG_COUNT];

   // Storage and read strobe
   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         for (int i = 0; i < REG_COUNT; i++)
            regs[i] <= '0;
         rdValid <= 1'b0;
      end
      else
      begin
         if (rfReq.wrEn)
            regs[rfReq.addr] <= rfReq.wrData;
         rdValid <= rfReq.rdEn;
      end
   end

   // Read data registered alongside rdValid
   always_ff @(posedge CLK)
   begin
      if (rfReq.rdEn)
         rdData <= regs[rfReq.addr];
   end

   // ALU operands live in the first two registers
   assign operandA = regs[0];
   assign operandB = regs[1];

endmodule

`default_nettype wire

// File: rtl/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit
   import cmdPkg::*;
(
   input  wire         CLK,
   input  wire         RST,
   input  wire byteT   operandA,
   input  wire byteT   operandB,
   input  wire aluReqT aluReq,
   output byteT        aluOut,
   output logic        outValid
);

   byteT result;

   // Everything truncates to one byte
   always_comb
   begin
      case (aluReq.fun)
         FUN_ADD:  result = operandA + operandB;
         FUN_SUB:  result = operandA - operandB;
         FUN_MUL:  result = operandA * operandB;
         FUN_DIV:  result = (operandB == '0) ? '0 : operandA / operandB;
         FUN_AND:  result = operandA & operandB;
         FUN_OR:   result = operandA | operandB;
         FUN_NAND: result = ~(operandA & operandB);
         FUN_NOR:  result = ~(operandA | operandB);
         FUN_XOR:  result = operandA ^ operandB;
         FUN_XNOR: result = ~(operandA ^ operandB);
         FUN_EQ:   result = byteT'(operandA == operandB);
         FUN_GT:   result = byteT'(operandA > operandB);
         FUN_SHR:  result = operandA >> 1;
         FUN_SHL:  result = operandA << 1;
         default:  result = '0;
      endcase
   end

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
         outValid <= 1'b0;
      else
         outValid <= aluReq.en;
   end

   // Result held until the next request
   always_ff @(posedge CLK)
   begin
      if (aluReq.en)
         aluOut <= result;
   end

   // Decoder waits for each result before another request
   assert property (@(posedge CLK) disable iff (!RST) outValid |=> !outValid);

endmodule

`default_nettype wire

// File: rtl/cmdDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module cmdDecoder
   import cmdPkg::*;
(
   input  wire        CLK,
   input  wire        RST,
   input  wire byteT  rxData,
   input  wire        rxValid,
   input  wire byteT  rdData,
   input  wire        rdValid,
   input  wire byteT  aluOut,
   input  wire        outValid,
   input  wire        txFull,
   output rfReqT      rfReq,
   output aluReqT     aluReq,
   output byteT       txByte,
   output logic       txPush
);

   typedef enum logic [3:0] {
      IDLE,
      COMMAND,
      ADDRESS,
      DATA,
      READ_WAIT,
      OPERAND_A,
      OPERAND_B,
      FUNCTION,
      ALU_WAIT,
      SEND
   } stateT;

   stateT state;
   byteT  cmdReg;
   byteT  replyByte;

   // Reply leaves as soon as the queue has room
   assign txByte = replyByte;
   assign txPush = (state == SEND) && !txFull;

   always_ff @(posedge CLK or negedge RST)
   begin
      if (!RST)
      begin
         state     <= IDLE;
         cmdReg    <= '0;
         replyByte <= '0;
         rfReq     <= '0;
         aluReq    <= '0;
      end
      else
      begin
         // Request strobes last one cycle
         rfReq.wrEn <= 1'b0;
         rfReq.rdEn <= 1'b0;
         aluReq.en  <= 1'b0;

         case (state)
            IDLE:
               if (rxValid)
               begin
                  cmdReg <= rxData;
                  state  <= COMMAND;
               end
            COMMAND:
               case (cmdReg)
                  CMD_RF_WR,
                  CMD_RF_RD:     state <= ADDRESS;
                  CMD_ALU_OPER:  state <= OPERAND_A;
                  CMD_ALU_NOPER: state <= FUNCTION;
                  default:       state <= IDLE;   // unknown byte is dropped
               endcase
            ADDRESS:
               if (rxValid)
               begin
                  rfReq.addr <= rxData[ADDR_WIDTH-1:0];
                  if (cmdReg == CMD_RF_RD)
                  begin
                     rfReq.rdEn <= 1'b1;
                     state      <= READ_WAIT;
                  end
                  else
                     state <= DATA;
               end
            DATA:
               if (rxValid)
               begin
                  rfReq.wrEn   <= 1'b1;
                  rfReq.wrData <= rxData;
                  state        <= IDLE;
               end
            READ_WAIT:
               if (rdValid)
               begin
                  replyByte <= rdData;
                  state     <= SEND;
               end
            // Operands go straight into registers 0 and 1
            OPERAND_A:
               if (rxValid)
               begin
                  rfReq.wrEn   <= 1'b1;
                  rfReq.addr   <= addrT'(0);
                  rfReq.wrData <= rxData;
                  state        <= OPERAND_B;
               end
            OPERAND_B:
               if (rxValid)
               begin
                  rfReq.wrEn   <= 1'b1;
                  rfReq.addr   <= addrT'(1);
                  rfReq.wrData <= rxData;
                  state        <= FUNCTION;
               end
            FUNCTION:
               if (rxValid)
               begin
                  aluReq.en  <= 1'b1;
                  aluReq.fun <= rxData[3:0];
                  state      <= ALU_WAIT;
               end
            ALU_WAIT:
               if (outValid)
               begin
                  replyByte <= aluOut;
                  state     <= SEND;
               end
            SEND:
               if (!txFull)
                  state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // A register request is either a write or a read, never both
   assert property (@(posedge CLK) disable iff (!RST) !(rfReq.wrEn && rfReq.rdEn));

endmodule

`default_nettype wire

// File: rtl/cmdSystem.sv
`timescale 1ns/10ps
`default_nettype none

module cmdSystem
   import cmdPkg::*;
(
   input  wire       CLK,
   input  wire       RST,
   input  wire byteT rxData,
   input  wire       rxValid,
   input  wire       txPop,
   output byteT      txData,
   output logic      txEmpty,
   output logic      txFull
);

   rfReqT  rfReq;
   aluReqT aluReq;
   byteT   rdData;
   logic   rdValid;
   byteT   operandA;
   byteT   operandB;
   byteT   aluOut;
   logic   outValid;
   byteT   txByte;
   logic   txPush;

   cmdDecoder cmdDecoder_inst (
      .CLK      (CLK),
      .RST      (RST),
      .rxData   (rxData),
      .rxValid  (rxValid),
      .rdData   (rdData),
      .rdValid  (rdValid),
      .aluOut   (aluOut),
      .outValid (outValid),
      .txFull   (txFull),
      .rfReq    (rfReq),
      .aluReq   (aluReq),
      .txByte   (txByte),
      .txPush   (txPush)
   );

   regFile regFile_inst (
      .CLK      (CLK),
      .RST      (RST),
      .rfReq    (rfReq),
      .rdData   (rdData),
      .rdValid  (rdValid),
      .operandA (operandA),
      .operandB (operandB)
   );

   aluUnit aluUnit_inst (
      .CLK      (CLK),
      .RST      (RST),
      .operandA (operandA),
      .operandB (operandB),
      .aluReq   (aluReq),
      .aluOut   (aluOut),
      .outValid (outValid)
   );

   // Replies queue here for the transmitter
   txFifo txFifo_inst (
      .CLK      (CLK),
      .RST      (RST),
      .push     (txPush),
      .pushData (txByte),
      .pop      (txPop),
      .popData  (txData),
      .full     (txFull),
      .empty    (txEmpty)
   );

endmodule

`default_nettype wire

// File: testbench/cmdSystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module cmdSystemTb
   import cmdPkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 10;
   localparam int BYTE_CYCLES  = 4;
   localparam int REPLY_LIMIT  = 20;
   // Bytes per command plus the longest reply wait summed over all tests
   localparam int TEST_CYCLES  =
      14 * 3 * BYTE_CYCLES + 14 * (2 * BYTE_CYCLES + REPLY_LIMIT) +
      18 * (4 * BYTE_CYCLES + REPLY_LIMIT) +
      5 * (2 * BYTE_CYCLES + REPLY_LIMIT) +
      9 * (2 * BYTE_CYCLES + REPLY_LIMIT) +
      3 * BYTE_CYCLES + REPLY_LIMIT + 40;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

   logic        CLK;
   logic        RST;
   byteT        rxData;
   logic        rxValid;
   logic        txPop;
   byteT        txData;
   logic        txEmpty;
   logic        txFull;

   int          errorCount = 0;
   int          checkCount = 0;
   logic [31:0] lcgState = 32'd91;
   byteT        regModel [REG_COUNT];

   cmdSystem cmdSystem_inst (
      .CLK     (CLK),
      .RST     (RST),
      .rxData  (rxData),
      .rxValid (rxValid),
      .txPop   (txPop),
      .txData  (txData),
      .txEmpty (txEmpty),
      .txFull  (txFull)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   function automatic byteT nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[23:16];
   endfunction

   // Reference results straight from the function table
   function automatic byteT expectedAlu(input byteT a, input byteT b, input aluFunT fun);
      case (fun)
         FUN_ADD:  return byteT'(a + b);
         FUN_SUB:  return byteT'(a - b);
         FUN_MUL:  return byteT'(a * b);
         FUN_DIV:  return (b == 8'd0) ? 8'd0 : byteT'(a / b);
         FUN_AND:  return a & b;
         FUN_OR:   return a | b;
         FUN_NAND: return ~(a & b);
         FUN_NOR:  return ~(a | b);
         FUN_XOR:  return a ^ b;
         FUN_XNOR: return ~(a ^ b);
         FUN_EQ:   return (a == b) ? 8'd1 : 8'd0;
         FUN_GT:   return (a > b) ? 8'd1 : 8'd0;
         FUN_SHR:  return {1'b0, a[7:1]};
         FUN_SHL:  return {a[6:0], 1'b0};
         default:  return 8'd0;
      endcase
   endfunction

   task automatic checkValue(input string testName, input byteT expected, input byteT actual);
      checkCount++;
      if (expected !== actual)
      begin
         errorCount++;
         $display("FAILED %s: expected 0x%02h, actual 0x%02h", testName, expected, actual);
      end
   endtask

   // One strobe then two idle cycles
   task automatic sendByte(input byteT value);
      @(posedge CLK);
      rxData  <= value;
      rxValid <= 1'b1;
      @(posedge CLK);
      rxValid <= 1'b0;
      repeat (2) @(posedge CLK);
   endtask

   task automatic popReply(input string testName, output byteT value);
      int waitCycles;
      waitCycles = 0;
      value = 8'd0;
      @(posedge CLK);
      while (txEmpty && waitCycles < REPLY_LIMIT)
      begin
         @(posedge CLK);
         waitCycles++;
      end
      if (txEmpty)
      begin
         errorCount++;
         $display("ERROR %s: no reply arrived within %0d cycles", testName, REPLY_LIMIT);
      end
      else
      begin
         value = txData;
         txPop <= 1'b1;
         @(posedge CLK);
         txPop <= 1'b0;
      end
   endtask

   task automatic readAndCheck(input string testName, input int addr);
      byteT reply;
      sendByte(CMD_RF_RD);
      sendByte(byteT'(addr));
      popReply(testName, reply);
      checkValue(testName, regModel[addr], reply);
   endtask

   task automatic writeReadRegisters();
      byteT value;
      for (int addr = 2; addr < REG_COUNT; addr++)
      begin
         value = nextRandom();
         sendByte(CMD_RF_WR);
         sendByte(byteT'(addr));
         sendByte(value);
         regModel[addr] = value;
      end
      // Writes are silent
      repeat (6) @(posedge CLK);
      checkValue("writeRead no reply", 8'd1, byteT'(txEmpty));
      for (int addr = 2; addr < REG_COUNT; addr++)
         readAndCheck($sformatf("writeRead addr %0d", addr), addr);
   endtask

   task automatic aluWithOperands(input byteT a, input byteT b, input aluFunT fun);
      byteT  reply;
      string name;
      name = $sformatf("aluOperands fun %0d", fun);
      sendByte(CMD_ALU_OPER);
      sendByte(a);
      sendByte(b);
      sendByte(byteT'(fun));
      regModel[0] = a;
      regModel[1] = b;
      popReply(name, reply);
      checkValue(name, expectedAlu(a, b, fun), reply);
   endtask

   task automatic sweepAluFunctions();
      byteT a;
      byteT b;
      // Corner cases random data rarely hits
      aluWithOperands(nextRandom(), 8'd0, FUN_DIV);
      a = nextRandom();
      aluWithOperands(a, a, FUN_EQ);
      // Random operands stay in registers 0 and 1 afterwards
      for (int f = 0; f < 16; f++)
      begin
         a = nextRandom();
         b = nextRandom();
         aluWithOperands(a, b, aluFunT'(f));
      end
   endtask

   task automatic reuseStoredOperands();
      aluFunT funList [3];
      byteT   reply;
      string  name;
      funList[0] = FUN_ADD;
      funList[1] = FUN_XOR;
      funList[2] = FUN_GT;
      for (int i = 0; i < 3; i++)
      begin
         name = $sformatf("aluStored fun %0d", funList[i]);
         sendByte(CMD_ALU_NOPER);
         sendByte(byteT'(funList[i]));
         popReply(name, reply);
         checkValue(name, expectedAlu(regModel[0], regModel[1], funList[i]), reply);
      end
      readAndCheck("aluStored operand A", 0);
      readAndCheck("aluStored operand B", 1);
   endtask

   task automatic fillReplyQueue();
      byteT reply;
      // One read more than the queue holds
      for (int i = 0; i <= FIFO_DEPTH; i++)
      begin
         sendByte(CMD_RF_RD);
         sendByte(byteT'(2 + i));
      end
      checkValue("backPressure full", 8'd1, byteT'(txFull));
      for (int i = 0; i <= FIFO_DEPTH; i++)
      begin
         popReply($sformatf("backPressure reply %0d", i), reply);
         checkValue($sformatf("backPressure reply %0d", i), regModel[2 + i], reply);
      end
      @(posedge CLK);
      checkValue("backPressure drained", 8'd1, byteT'(txEmpty));
   endtask

   task automatic rejectUnknownCommand();
      sendByte(8'h5A);
      repeat (6) @(posedge CLK);
      checkValue("unknownCommand no reply", 8'd1, byteT'(txEmpty));
      readAndCheck("unknownCommand recovery", 5);
   endtask

   initial
   begin
      RST     <= 1'b0;
      rxData  <= '0;
      rxValid <= 1'b0;
      txPop   <= 1'b0;
      for (int i = 0; i < REG_COUNT; i++)
         regModel[i] = 8'd0;
      repeat (RESET_CYCLES) @(posedge CLK);
      RST <= 1'b1;
      @(posedge CLK);

      writeReadRegisters();
      sweepAluFunctions();
      reuseStoredOperands();
      fillReplyQueue();
      rejectUnknownCommand();

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
rtl/cmdPkg.sv
rtl/txFifo.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/cmdDecoder.sv
rtl/cmdSystem.sv
testbench/cmdSystemTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cmdSystemTb
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
